//--- axi_corebus_bridge.f
logic/axi_defs_pkg.sv
logic/corebus_defs_pkg.sv
logic/corebus_if.sv
logic/sync_fifo.sv
logic/axi_request_converter.sv
logic/corebus_request_fifo.sv
logic/corebus_request_arbiter.sv
logic/axi_response_unit.sv
logic/axi_corebus_bridge.sv
bench/bridge_asserts.sv
bench/bridge_tb.sv

//--- bench/bridge_asserts.sv
// Concurrent checks on the bridge handshakes, bound into the top level.
// Valids hold with a stable payload until taken; B is idle out of reset.
module bridge_asserts
  import axi_defs_pkg::*, corebus_defs_pkg::*;
(
  input logic       i_clk,
  input logic       i_rst_n,
  input logic       o_cb_cmd_valid,
  input logic       i_cb_cmd_accept,
  input cb_cmd_t    o_cb_cmd,
  input axi_id_t    o_cb_cmd_id,
  input cb_addr_t   o_cb_cmd_addr,
  input cb_length_t o_cb_cmd_length,
  input logic       o_cb_data_valid,
  input logic       i_cb_data_accept,
  input cb_data_t   o_cb_data,
  input cb_byteen_t o_cb_data_byteen,
  input logic       o_cb_data_last,
  input logic       o_bvalid,
  input logic       i_bready,
  input axi_id_t    o_bid
);
  timeunit 1ns;
  timeprecision 100ps;

  cmd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_cb_cmd_valid && !i_cb_cmd_accept |=> o_cb_cmd_valid
      && $stable({o_cb_cmd, o_cb_cmd_id, o_cb_cmd_addr, o_cb_cmd_length}))
    else $error("corebus command dropped or changed before it was accepted");

  data_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_cb_data_valid && !i_cb_data_accept |=> o_cb_data_valid
      && $stable({o_cb_data, o_cb_data_byteen, o_cb_data_last}))
    else $error("corebus data beat dropped or changed before it was accepted");

  b_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_bvalid && !i_bready |=> o_bvalid && $stable(o_bid))
    else $error("B response dropped or changed before it was taken");

  // first cycle out of reset
  b_idle_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !o_bvalid)
    else $error("B valid high in the first cycle after reset");

endmodule

bind axi_corebus_bridge bridge_asserts u_asserts (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .o_cb_cmd_valid   (o_cb_cmd_valid),
  .i_cb_cmd_accept  (i_cb_cmd_accept),
  .o_cb_cmd         (o_cb_cmd),
  .o_cb_cmd_id      (o_cb_cmd_id),
  .o_cb_cmd_addr    (o_cb_cmd_addr),
  .o_cb_cmd_length  (o_cb_cmd_length),
  .o_cb_data_valid  (o_cb_data_valid),
  .i_cb_data_accept (i_cb_data_accept),
  .o_cb_data        (o_cb_data),
  .o_cb_data_byteen (o_cb_data_byteen),
  .o_cb_data_last   (o_cb_data_last),
  .o_bvalid         (o_bvalid),
  .i_bready         (i_bready),
  .o_bid            (o_bid)
);

//--- bench/bridge_tb.sv
// Testbench for the AXI to corebus bridge.
// Random AXI bursts and corebus stalls come from an LFSR; commands, write
// beats, R beats and B responses are checked against queued expectations.
module bridge_tb
  import axi_defs_pkg::*, corebus_defs_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BURSTS     = 200;
  localparam int MAX_BEATS      = 8;
  localparam int RESET_CYCLES   = 16;
  localparam int TOTAL_BEATS    = 2 * NUM_BURSTS * MAX_BEATS;
  localparam int TIMEOUT_CYCLES = 40 * TOTAL_BEATS;

  typedef struct packed {
    axi_id_t    id;
    cb_addr_t   addr;
    cb_length_t length;
    axi_len_t   len;
  } cmd_exp_t;

  typedef struct packed {
    cb_data_t   data;
    cb_byteen_t strb;
    logic       last;
  } beat_exp_t;

  typedef struct packed {
    axi_id_t  id;
    cb_data_t data;
    logic     error;
    logic     last;
  } resp_beat_t;

  logic       i_clk;
  logic       i_rst_n;
  logic       i_arvalid, o_arready;
  axi_id_t    i_arid;
  axi_addr_t  i_araddr;
  axi_len_t   i_arlen;
  logic       o_rvalid, i_rready, o_rlast;
  axi_id_t    o_rid;
  cb_data_t   o_rdata;
  axi_resp_t  o_rresp;
  logic       i_awvalid, o_awready;
  axi_id_t    i_awid;
  axi_addr_t  i_awaddr;
  axi_len_t   i_awlen;
  logic       i_wvalid, o_wready, i_wlast;
  cb_data_t   i_wdata;
  cb_byteen_t i_wstrb;
  logic       o_bvalid, i_bready;
  axi_id_t    o_bid;
  axi_resp_t  o_bresp;
  logic       o_cb_cmd_valid, i_cb_cmd_accept;
  cb_cmd_t    o_cb_cmd;
  axi_id_t    o_cb_cmd_id;
  cb_addr_t   o_cb_cmd_addr;
  cb_length_t o_cb_cmd_length;
  logic       o_cb_data_valid, i_cb_data_accept, o_cb_data_last;
  cb_data_t   o_cb_data;
  cb_byteen_t o_cb_data_byteen;
  logic       i_cb_resp_valid, o_cb_resp_accept, i_cb_resp_error, i_cb_resp_last;
  axi_id_t    i_cb_resp_id;
  cb_data_t   i_cb_resp_data;

  logic [15:0] lfsr_state = 16'd60529;
  logic        running;
  int          cycle_count = 0;
  int          ar_sent, aw_sent, w_beat;
  int          ar_fired, aw_fired, wlast_fired, b_seen, cmds_seen;
  int          r_seen, rd_beats_total, wbeats_seen, wr_beats_total;

  cmd_exp_t   rd_cmd_q[$];
  cmd_exp_t   wr_cmd_q[$];
  beat_exp_t  wdata_q[$];
  resp_beat_t resp_q[$];
  axi_id_t    bid_q[$];
  axi_len_t   wlen_q[$];

  axi_corebus_bridge #(
    .CMD_FIFO_DEPTH  (2),
    .DATA_FIFO_DEPTH (2),
    .BID_FIFO_DEPTH  (8)
  ) dut0 (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // unit-aligned address, length in 32-bit units less the skipped first unit
  function automatic cmd_exp_t expect_cmd(axi_id_t id, axi_addr_t addr, axi_len_t len);
    cmd_exp_t c;
    c.id     = id;
    c.addr   = {addr[31:2], 2'b00};
    c.length = cb_length_t'(2 * (int'(len) + 1) - int'(addr[2]));
    c.len    = len;
    return c;
  endfunction

  task automatic fail_run(string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_addr(string name, cb_addr_t expected, cb_addr_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic compare_length(string name, cb_length_t expected, cb_length_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic compare_data(string name, cb_data_t expected, cb_data_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic compare_byteen(string name, cb_byteen_t expected, cb_byteen_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic compare_id(string name, axi_id_t expected, axi_id_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic compare_resp(string name, axi_resp_t expected, axi_resp_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic compare_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %h got %h", name, expected, actual));
    end
  endtask

  task automatic require_idle_outputs();
    compare_bit("o_cb_cmd_valid", 1'b0, o_cb_cmd_valid);
    compare_bit("o_cb_data_valid", 1'b0, o_cb_data_valid);
    compare_bit("o_bvalid", 1'b0, o_bvalid);
  endtask

  // corebus side, sampled before the edge
  task automatic observe_corebus();
    cmd_exp_t   c;
    beat_exp_t  w;
    resp_beat_t r;
    if (o_cb_cmd_valid && i_cb_cmd_accept) begin
      cmds_seen++;
      if (o_cb_cmd == CB_CMD_READ) begin
        if (rd_cmd_q.size() == 0) begin
          fail_run("corebus READ command with no AR outstanding");
        end
        c = rd_cmd_q.pop_front();
        // responder queues one beat per AXI beat
        for (int i = 0; i <= int'(c.len); i++) begin
          r.id    = c.id;
          r.data  = cb_data_t'(rand_bits(64));
          r.error = (rand_bits(3) == '0);
          r.last  = (i == int'(c.len));
          resp_q.push_back(r);
        end
      end else if (o_cb_cmd == CB_CMD_WRITE) begin
        if (wr_cmd_q.size() == 0) begin
          fail_run("corebus WRITE command with no AW outstanding");
        end
        c = wr_cmd_q.pop_front();
      end else begin
        fail_run($sformatf("** Error: o_cb_cmd expected 1 or 2 got %h", o_cb_cmd));
      end
      compare_id("o_cb_cmd_id", c.id, o_cb_cmd_id);
      compare_addr("o_cb_cmd_addr", c.addr, o_cb_cmd_addr);
      compare_length("o_cb_cmd_length", c.length, o_cb_cmd_length);
    end
    if (o_cb_data_valid && i_cb_data_accept) begin
      if (wdata_q.size() == 0) begin
        fail_run("corebus data beat with no W beat outstanding");
      end
      w = wdata_q.pop_front();
      compare_data("o_cb_data", w.data, o_cb_data);
      compare_byteen("o_cb_data_byteen", w.strb, o_cb_data_byteen);
      compare_bit("o_cb_data_last", w.last, o_cb_data_last);
      wbeats_seen++;
    end
    compare_bit("o_rvalid", i_cb_resp_valid, o_rvalid);
    compare_bit("o_cb_resp_accept", i_rready, o_cb_resp_accept);
    if (i_cb_resp_valid && o_cb_resp_accept) begin
      r = resp_q.pop_front();
      compare_id("o_rid", r.id, o_rid);
      compare_data("o_rdata", r.data, o_rdata);
      compare_resp("o_rresp", r.error ? AXI_RESP_SLVERR : AXI_RESP_OKAY, o_rresp);
      compare_bit("o_rlast", r.last, o_rlast);
      r_seen++;
    end
  endtask

  task automatic observe_axi();
    beat_exp_t w;
    if (o_bvalid) begin
      if (b_seen >= aw_fired || b_seen >= wlast_fired) begin
        fail_run("B response raised before its AW and last W beat were taken");
      end
      if (i_bready) begin
        compare_id("o_bid", bid_q.pop_front(), o_bid);
        compare_resp("o_bresp", AXI_RESP_OKAY, o_bresp);
        b_seen++;
      end
    end
    if (i_arvalid && o_arready) begin
      rd_cmd_q.push_back(expect_cmd(i_arid, i_araddr, i_arlen));
      rd_beats_total += int'(i_arlen) + 1;
      ar_fired++;
    end
    if (i_awvalid && o_awready) begin
      wr_cmd_q.push_back(expect_cmd(i_awid, i_awaddr, i_awlen));
      bid_q.push_back(i_awid);
      wr_beats_total += int'(i_awlen) + 1;
      aw_fired++;
    end
    if (i_wvalid && o_wready) begin
      w.data = i_wdata;
      w.strb = i_wstrb;
      w.last = i_wlast;
      wdata_q.push_back(w);
      if (i_wlast) begin
        wlast_fired++;
      end
    end
  endtask

  // a valid only moves on once the current payload has been taken
  task drive_axi();
    if (!i_arvalid || o_arready) begin
      if (ar_sent < NUM_BURSTS && rand_bits(2) != '0) begin
        i_arvalid <= 1'b1;
        i_arid    <= axi_id_t'(rand_bits(4));
        i_araddr  <= axi_addr_t'(rand_bits(32));
        i_arlen   <= axi_len_t'(rand_bits(3));
        ar_sent++;
      end else begin
        i_arvalid <= 1'b0;
      end
    end
    if (!i_awvalid || o_awready) begin
      if (aw_sent < NUM_BURSTS && rand_bits(2) != '0) begin
        i_awvalid <= 1'b1;
        i_awid    <= axi_id_t'(rand_bits(4));
        i_awaddr  <= axi_addr_t'(rand_bits(32));
        wlen_q.push_back(axi_len_t'(rand_bits(3)));
        i_awlen   <= wlen_q[wlen_q.size() - 1];
        aw_sent++;
      end else begin
        i_awvalid <= 1'b0;
      end
    end
    if (!i_wvalid || o_wready) begin
      if (wlen_q.size() != 0 && rand_bits(2) != '0) begin
        i_wvalid <= 1'b1;
        i_wdata  <= cb_data_t'(rand_bits(64));
        i_wstrb  <= cb_byteen_t'(rand_bits(8));
        i_wlast  <= (w_beat == int'(wlen_q[0]));
        if (w_beat == int'(wlen_q[0])) begin
          wlen_q.delete(0);
          w_beat = 0;
        end else begin
          w_beat++;
        end
      end else begin
        i_wvalid <= 1'b0;
      end
    end
  endtask

  task drive_corebus();
    i_cb_cmd_accept  <= (rand_bits(2) != '0);
    i_cb_data_accept <= (rand_bits(2) != '0);
    i_bready         <= (rand_bits(2) != '0);
    i_rready         <= (rand_bits(2) != '0);
    if (!i_cb_resp_valid || o_cb_resp_accept) begin
      if (resp_q.size() != 0 && rand_bits(2) != '0) begin
        i_cb_resp_valid <= 1'b1;
        i_cb_resp_id    <= resp_q[0].id;
        i_cb_resp_data  <= resp_q[0].data;
        i_cb_resp_error <= resp_q[0].error;
        i_cb_resp_last  <= resp_q[0].last;
      end else begin
        i_cb_resp_valid <= 1'b0;
      end
    end
  endtask

  always @(posedge i_clk) begin
    if (running) begin
      observe_corebus();
      observe_axi();
      drive_axi();
      drive_corebus();
    end
  end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout after %0d cycles with traffic still pending",
                         TIMEOUT_CYCLES));
    end
  end

  function automatic logic traffic_done();
    return (ar_fired == NUM_BURSTS) && (aw_fired == NUM_BURSTS)
      && (b_seen == NUM_BURSTS) && (cmds_seen == 2 * NUM_BURSTS)
      && (r_seen == rd_beats_total) && (wbeats_seen == wr_beats_total);
  endfunction

  initial begin
    running          <= 1'b0;
    i_rst_n          <= 1'b0;
    i_arvalid        <= 1'b0;
    i_arid           <= '0;
    i_araddr         <= '0;
    i_arlen          <= '0;
    i_rready         <= 1'b0;
    i_awvalid        <= 1'b0;
    i_awid           <= '0;
    i_awaddr         <= '0;
    i_awlen          <= '0;
    i_wvalid         <= 1'b0;
    i_wdata          <= '0;
    i_wstrb          <= '0;
    i_wlast          <= 1'b0;
    i_bready         <= 1'b0;
    i_cb_cmd_accept  <= 1'b0;
    i_cb_data_accept <= 1'b0;
    i_cb_resp_valid  <= 1'b0;
    i_cb_resp_id     <= '0;
    i_cb_resp_data   <= '0;
    i_cb_resp_error  <= 1'b0;
    i_cb_resp_last   <= 1'b0;
    // flops take reset at the first edge
    @(posedge i_clk);
    repeat (RESET_CYCLES - 1) begin
      @(posedge i_clk);
      require_idle_outputs();
    end
    i_rst_n <= 1'b1;
    @(posedge i_clk);
    require_idle_outputs();
    running <= 1'b1;
    while (!traffic_done()) begin
      @(negedge i_clk);
    end
    if (rd_cmd_q.size() != 0 || wr_cmd_q.size() != 0 || wdata_q.size() != 0
        || resp_q.size() != 0 || bid_q.size() != 0 || wlen_q.size() != 0) begin
      fail_run("expected queues not empty at the end of the run");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

//--- logic/axi_corebus_bridge.sv
// AXI slave to corebus master bridge, top level.
// Reads and writes are queued apart and merged round-robin onto corebus;
// read data returns on R, and B is generated inside the bridge.
module axi_corebus_bridge
  import axi_defs_pkg::*, corebus_defs_pkg::*;
#(
  parameter int CMD_FIFO_DEPTH  = 2,
  parameter int DATA_FIFO_DEPTH = 2,
  parameter int BID_FIFO_DEPTH  = 8
) (
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_arvalid,
  output logic       o_arready,
  input  axi_id_t    i_arid,
  input  axi_addr_t  i_araddr,
  input  axi_len_t   i_arlen,
  output logic       o_rvalid,
  input  logic       i_rready,
  output axi_id_t    o_rid,
  output cb_data_t   o_rdata,
  output axi_resp_t  o_rresp,
  output logic       o_rlast,
  input  logic       i_awvalid,
  output logic       o_awready,
  input  axi_id_t    i_awid,
  input  axi_addr_t  i_awaddr,
  input  axi_len_t   i_awlen,
  input  logic       i_wvalid,
  output logic       o_wready,
  input  cb_data_t   i_wdata,
  input  cb_byteen_t i_wstrb,
  input  logic       i_wlast,
  output logic       o_bvalid,
  input  logic       i_bready,
  output axi_id_t    o_bid,
  output axi_resp_t  o_bresp,
  output logic       o_cb_cmd_valid,
  input  logic       i_cb_cmd_accept,
  output cb_cmd_t    o_cb_cmd,
  output axi_id_t    o_cb_cmd_id,
  output cb_addr_t   o_cb_cmd_addr,
  output cb_length_t o_cb_cmd_length,
  output logic       o_cb_data_valid,
  input  logic       i_cb_data_accept,
  output cb_data_t   o_cb_data,
  output cb_byteen_t o_cb_data_byteen,
  output logic       o_cb_data_last,
  input  logic       i_cb_resp_valid,
  output logic       o_cb_resp_accept,
  input  axi_id_t    i_cb_resp_id,
  input  cb_data_t   i_cb_resp_data,
  input  logic       i_cb_resp_error,
  input  logic       i_cb_resp_last
);

  logic bid_full;
  logic burst_count_full;
  logic aw_fire;
  logic wlast_fire;

  assign aw_fire    = i_awvalid && o_awready;
  assign wlast_fire = i_wvalid && o_wready && i_wlast;

  corebus_if #(.ID_WIDTH(AXI_ID_WIDTH)) rd_req ();
  corebus_if #(.ID_WIDTH(AXI_ID_WIDTH)) wr_req ();
  corebus_if #(.ID_WIDTH(AXI_ID_WIDTH)) rd_q ();
  corebus_if #(.ID_WIDTH(AXI_ID_WIDTH)) wr_q ();

  axi_request_converter u_converter (
    .i_arvalid          (i_arvalid),
    .o_arready          (o_arready),
    .i_arid             (i_arid),
    .i_araddr           (i_araddr),
    .i_arlen            (i_arlen),
    .i_awvalid          (i_awvalid),
    .o_awready          (o_awready),
    .i_awid             (i_awid),
    .i_awaddr           (i_awaddr),
    .i_awlen            (i_awlen),
    .i_wvalid           (i_wvalid),
    .o_wready           (o_wready),
    .i_wdata            (i_wdata),
    .i_wstrb            (i_wstrb),
    .i_wlast            (i_wlast),
    .i_bid_full         (bid_full),
    .i_burst_count_full (burst_count_full),
    .rd_req             (rd_req),
    .wr_req             (wr_req)
  );

  corebus_request_fifo #(
    .CMD_DEPTH  (CMD_FIFO_DEPTH),
    .DATA_DEPTH (0),
    .ID_WIDTH   (AXI_ID_WIDTH)
  ) u_read_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .s_req   (rd_req),
    .m_req   (rd_q)
  );

  corebus_request_fifo #(
    .CMD_DEPTH  (CMD_FIFO_DEPTH),
    .DATA_DEPTH (DATA_FIFO_DEPTH),
    .ID_WIDTH   (AXI_ID_WIDTH)
  ) u_write_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .s_req   (wr_req),
    .m_req   (wr_q)
  );

  corebus_request_arbiter #(
    .ID_WIDTH (AXI_ID_WIDTH)
  ) u_arbiter (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .rd_q             (rd_q),
    .wr_q             (wr_q),
    .o_cb_cmd_valid   (o_cb_cmd_valid),
    .i_cb_cmd_accept  (i_cb_cmd_accept),
    .o_cb_cmd         (o_cb_cmd),
    .o_cb_cmd_id      (o_cb_cmd_id),
    .o_cb_cmd_addr    (o_cb_cmd_addr),
    .o_cb_cmd_length  (o_cb_cmd_length),
    .o_cb_data_valid  (o_cb_data_valid),
    .i_cb_data_accept (i_cb_data_accept),
    .o_cb_data        (o_cb_data),
    .o_cb_data_byteen (o_cb_data_byteen),
    .o_cb_data_last   (o_cb_data_last)
  );

  axi_response_unit #(
    .BID_FIFO_DEPTH (BID_FIFO_DEPTH)
  ) u_response (
    .i_clk              (i_clk),
    .i_rst_n            (i_rst_n),
    .i_cb_resp_valid    (i_cb_resp_valid),
    .o_cb_resp_accept   (o_cb_resp_accept),
    .i_cb_resp_id       (i_cb_resp_id),
    .i_cb_resp_data     (i_cb_resp_data),
    .i_cb_resp_error    (i_cb_resp_error),
    .i_cb_resp_last     (i_cb_resp_last),
    .o_rvalid           (o_rvalid),
    .i_rready           (i_rready),
    .o_rid              (o_rid),
    .o_rdata            (o_rdata),
    .o_rresp            (o_rresp),
    .o_rlast            (o_rlast),
    .i_aw_fire          (aw_fire),
    .i_awid             (i_awid),
    .i_wlast_fire       (wlast_fire),
    .o_bvalid           (o_bvalid),
    .i_bready           (i_bready),
    .o_bid              (o_bid),
    .o_bresp            (o_bresp),
    .o_bid_full         (bid_full),
    .o_burst_count_full (burst_count_full)
  );

endmodule

//--- logic/axi_defs_pkg.sv
// AXI-side widths, field types and response codes.
// Imported by the blocks that face the AXI slave port.
package axi_defs_pkg;

  localparam int AXI_ID_WIDTH   = 4;
  localparam int AXI_ADDR_WIDTH = 32;

  typedef logic [AXI_ID_WIDTH-1:0]   axi_id_t;
  typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;

  // beats minus one
  typedef logic [7:0] axi_len_t;
  // log2 of bytes per beat
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY   = 2'd0;
  localparam axi_resp_t AXI_RESP_SLVERR = 2'd2;

endpackage

//--- logic/axi_request_converter.sv
// Turns AXI AR, AW and W into corebus read and write request streams.
// Purely combinational; AW and W are held off by the B tracking flags.
module axi_request_converter
  import axi_defs_pkg::*, corebus_defs_pkg::*;
(
  input  logic       i_arvalid,
  output logic       o_arready,
  input  axi_id_t    i_arid,
  input  axi_addr_t  i_araddr,
  input  axi_len_t   i_arlen,
  input  logic       i_awvalid,
  output logic       o_awready,
  input  axi_id_t    i_awid,
  input  axi_addr_t  i_awaddr,
  input  axi_len_t   i_awlen,
  input  logic       i_wvalid,
  output logic       o_wready,
  input  cb_data_t   i_wdata,
  input  cb_byteen_t i_wstrb,
  input  logic       i_wlast,
  input  logic       i_bid_full,
  input  logic       i_burst_count_full,
  corebus_if.master  rd_req,
  corebus_if.master  wr_req
);

  localparam int OFFSET_LSB   = $clog2(CB_UNIT_WIDTH / 8);
  localparam int OFFSET_WIDTH = $clog2(CB_UNITS_PER_BEAT);

  // unit-aligned address
  function automatic cb_addr_t unit_addr(axi_addr_t addr);
    return cb_addr_t'({addr[AXI_ADDR_WIDTH-1:OFFSET_LSB], OFFSET_LSB'(0)});
  endfunction

  // burst size in units, less the units skipped in the first beat
  function automatic cb_length_t unit_length(axi_addr_t addr, axi_len_t len);
    cb_length_t units;
    cb_length_t offset;
    units  = (cb_length_t'(len) + cb_length_t'(1)) * cb_length_t'(CB_UNITS_PER_BEAT);
    offset = cb_length_t'(addr[OFFSET_LSB+:OFFSET_WIDTH]);
    return units - offset;
  endfunction

  always_comb begin
    rd_req.cmd_valid = i_arvalid;
    o_arready        = rd_req.cmd_accept;
    rd_req.cmd       = CB_CMD_READ;
    rd_req.id        = i_arid;
    rd_req.addr      = unit_addr(i_araddr);
    rd_req.length    = unit_length(i_araddr, i_arlen);
    // reads carry no data
    rd_req.data_valid = 1'b0;
    rd_req.data       = '0;
    rd_req.byteen     = '0;
    rd_req.last       = 1'b0;
  end

  always_comb begin
    wr_req.cmd_valid = i_awvalid && !i_bid_full;
    o_awready        = wr_req.cmd_accept && !i_bid_full;
    wr_req.cmd       = CB_CMD_WRITE;
    wr_req.id        = i_awid;
    wr_req.addr      = unit_addr(i_awaddr);
    wr_req.length    = unit_length(i_awaddr, i_awlen);
    wr_req.data_valid = i_wvalid && !i_burst_count_full;
    o_wready          = wr_req.data_accept && !i_burst_count_full;
    wr_req.data       = i_wdata;
    wr_req.byteen     = i_wstrb;
    wr_req.last       = i_wlast;
  end

endmodule

//--- logic/axi_response_unit.sv
// Drives AXI R from corebus read responses and builds B locally.
// Writes are posted, so B waits only for the AW id and the wlast beat.
module axi_response_unit
  import axi_defs_pkg::*, corebus_defs_pkg::*;
#(
  parameter int BID_FIFO_DEPTH = 8
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  input  logic      i_cb_resp_valid,
  output logic      o_cb_resp_accept,
  input  axi_id_t   i_cb_resp_id,
  input  cb_data_t  i_cb_resp_data,
  input  logic      i_cb_resp_error,
  input  logic      i_cb_resp_last,
  output logic      o_rvalid,
  input  logic      i_rready,
  output axi_id_t   o_rid,
  output cb_data_t  o_rdata,
  output axi_resp_t o_rresp,
  output logic      o_rlast,
  input  logic      i_aw_fire,
  input  axi_id_t   i_awid,
  input  logic      i_wlast_fire,
  output logic      o_bvalid,
  input  logic      i_bready,
  output axi_id_t   o_bid,
  output axi_resp_t o_bresp,
  output logic      o_bid_full,
  output logic      o_burst_count_full
);

  localparam int COUNT_WIDTH = $clog2(BID_FIFO_DEPTH + 1);

  logic                   bid_empty;
  logic                   b_fire;
  logic [COUNT_WIDTH-1:0] burst_count;

  always_comb begin
    o_rvalid         = i_cb_resp_valid;
    o_cb_resp_accept = i_rready;
    o_rid            = i_cb_resp_id;
    o_rdata          = i_cb_resp_data;
    o_rresp          = i_cb_resp_error ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
    o_rlast          = i_cb_resp_last;
  end

  assign b_fire = o_bvalid && i_bready;

  sync_fifo #(
    .WIDTH (AXI_ID_WIDTH),
    .DEPTH (BID_FIFO_DEPTH)
  ) u_bid_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (i_aw_fire),
    .i_data  (i_awid),
    .i_pop   (b_fire),
    .o_data  (o_bid),
    .o_empty (bid_empty),
    .o_full  (o_bid_full)
  );

  // write bursts whose last beat went out but whose B has not
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      burst_count <= '0;
    end else if (i_wlast_fire && !b_fire) begin
      burst_count <= burst_count + COUNT_WIDTH'(1);
    end else if (b_fire && !i_wlast_fire) begin
      burst_count <= burst_count - COUNT_WIDTH'(1);
    end
  end

  assign o_burst_count_full = (burst_count == COUNT_WIDTH'(BID_FIFO_DEPTH));
  assign o_bvalid           = (burst_count != '0) && !bid_empty;
  assign o_bresp            = AXI_RESP_OKAY;

endmodule

//--- logic/corebus_defs_pkg.sv
// Corebus widths, command codes and field types.
// Lengths on corebus count 32-bit units, not beats.
package corebus_defs_pkg;

  localparam int CB_DATA_WIDTH     = 64;
  localparam int CB_UNIT_WIDTH     = 32;
  localparam int CB_UNITS_PER_BEAT = CB_DATA_WIDTH / CB_UNIT_WIDTH;

  typedef logic [1:0] cb_cmd_t;

  localparam cb_cmd_t CB_CMD_READ  = 2'd1;
  localparam cb_cmd_t CB_CMD_WRITE = 2'd2;

  typedef logic [31:0]                cb_addr_t;
  typedef logic [9:0]                 cb_length_t;
  typedef logic [CB_DATA_WIDTH-1:0]   cb_data_t;
  typedef logic [CB_DATA_WIDTH/8-1:0] cb_byteen_t;

endpackage

//--- logic/corebus_if.sv
// One corebus request stream: a command group and a data group.
// Both groups use valid/accept; a transfer is valid && accept.
interface corebus_if
  import corebus_defs_pkg::*;
#(
  parameter int ID_WIDTH = 4
) ();

  logic                cmd_valid;
  logic                cmd_accept;
  cb_cmd_t             cmd;
  logic [ID_WIDTH-1:0] id;
  cb_addr_t            addr;
  cb_length_t          length;

  logic                data_valid;
  logic                data_accept;
  cb_data_t            data;
  cb_byteen_t          byteen;
  logic                last;

  modport master (
    output cmd_valid, cmd, id, addr, length,
    input  cmd_accept,
    output data_valid, data, byteen, last,
    input  data_accept
  );

  modport slave (
    input  cmd_valid, cmd, id, addr, length,
    output cmd_accept,
    input  data_valid, data, byteen, last,
    output data_accept
  );

endinterface

//--- logic/corebus_request_arbiter.sv
// Merges the read and write command queues onto one corebus port.
// Round-robin between the two; write data goes straight through.
module corebus_request_arbiter
  import corebus_defs_pkg::*;
#(
  parameter int ID_WIDTH = 4
) (
  input  logic                i_clk,
  input  logic                i_rst_n,
  corebus_if.slave            rd_q,
  corebus_if.slave            wr_q,
  output logic                o_cb_cmd_valid,
  input  logic                i_cb_cmd_accept,
  output cb_cmd_t             o_cb_cmd,
  output logic [ID_WIDTH-1:0] o_cb_cmd_id,
  output cb_addr_t            o_cb_cmd_addr,
  output cb_length_t          o_cb_cmd_length,
  output logic                o_cb_data_valid,
  input  logic                i_cb_data_accept,
  output cb_data_t            o_cb_data,
  output cb_byteen_t          o_cb_data_byteen,
  output logic                o_cb_data_last
);

  // high when write has priority
  logic prio_wr;
  logic grant_rd;
  logic grant_wr;

  assign grant_rd = rd_q.cmd_valid && (!prio_wr || !wr_q.cmd_valid);
  assign grant_wr = wr_q.cmd_valid && !grant_rd;

  always_comb begin
    o_cb_cmd_valid  = grant_rd || grant_wr;
    o_cb_cmd        = grant_wr ? wr_q.cmd    : rd_q.cmd;
    o_cb_cmd_id     = grant_wr ? wr_q.id     : rd_q.id;
    o_cb_cmd_addr   = grant_wr ? wr_q.addr   : rd_q.addr;
    o_cb_cmd_length = grant_wr ? wr_q.length : rd_q.length;
    rd_q.cmd_accept = grant_rd && i_cb_cmd_accept;
    wr_q.cmd_accept = grant_wr && i_cb_cmd_accept;
  end

  // a stalled grant keeps priority, so the presented command stays put;
  // after a transfer the other side goes first
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      prio_wr <= 1'b0;
    end else if (o_cb_cmd_valid) begin
      prio_wr <= i_cb_cmd_accept ? grant_rd : grant_wr;
    end
  end

  always_comb begin
    o_cb_data_valid  = wr_q.data_valid;
    o_cb_data        = wr_q.data;
    o_cb_data_byteen = wr_q.byteen;
    o_cb_data_last   = wr_q.last;
    wr_q.data_accept = i_cb_data_accept;
    rd_q.data_accept = 1'b0;
  end

endmodule

//--- logic/corebus_request_fifo.sv
// Buffers one corebus request stream: a command queue and, when
// DATA_DEPTH is non-zero, a write data queue beside it.
module corebus_request_fifo
  import corebus_defs_pkg::*;
#(
  parameter int CMD_DEPTH  = 2,
  parameter int DATA_DEPTH = 2,
  parameter int ID_WIDTH   = 4
) (
  input  logic      i_clk,
  input  logic      i_rst_n,
  corebus_if.slave  s_req,
  corebus_if.master m_req
);

  localparam int CMD_WIDTH = $bits(cb_cmd_t) + ID_WIDTH + $bits(cb_addr_t) + $bits(cb_length_t);

  logic                 cmd_empty;
  logic                 cmd_full;
  logic [CMD_WIDTH-1:0] cmd_word;

  sync_fifo #(
    .WIDTH (CMD_WIDTH),
    .DEPTH (CMD_DEPTH)
  ) u_cmd_fifo (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_push  (s_req.cmd_valid),
    .i_data  ({s_req.cmd, s_req.id, s_req.addr, s_req.length}),
    .i_pop   (m_req.cmd_accept),
    .o_data  (cmd_word),
    .o_empty (cmd_empty),
    .o_full  (cmd_full)
  );

  assign s_req.cmd_accept = !cmd_full;
  assign m_req.cmd_valid  = !cmd_empty;
  assign {m_req.cmd, m_req.id, m_req.addr, m_req.length} = cmd_word;

  if (DATA_DEPTH > 0) begin : g_data
    localparam int DATA_WIDTH = $bits(cb_data_t) + $bits(cb_byteen_t) + 1;

    logic                  data_empty;
    logic                  data_full;
    logic [DATA_WIDTH-1:0] data_word;

    sync_fifo #(
      .WIDTH (DATA_WIDTH),
      .DEPTH (DATA_DEPTH)
    ) u_data_fifo (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_push  (s_req.data_valid),
      .i_data  ({s_req.data, s_req.byteen, s_req.last}),
      .i_pop   (m_req.data_accept),
      .o_data  (data_word),
      .o_empty (data_empty),
      .o_full  (data_full)
    );

    assign s_req.data_accept = !data_full;
    assign m_req.data_valid  = !data_empty;
    assign {m_req.data, m_req.byteen, m_req.last} = data_word;
  end else begin : g_no_data
    // stream carries commands only
    assign s_req.data_accept = 1'b0;
    assign m_req.data_valid  = 1'b0;
    assign m_req.data        = '0;
    assign m_req.byteen      = '0;
    assign m_req.last        = 1'b0;
  end

endmodule

//--- logic/sync_fifo.sv
// Single-clock circular FIFO with registered empty and full flags.
// Both flags are held high in reset so no push is taken then.
module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 2
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  logic             i_push,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_pop,
  output logic [WIDTH-1:0] o_data,
  output logic             o_empty,
  output logic             o_full
);

  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]       mem [DEPTH];
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic [COUNT_WIDTH-1:0] count_next;
  logic                   do_push;
  logic                   do_pop;

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;
  assign o_data  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (do_push && !do_pop) begin
      count_next = count + COUNT_WIDTH'(1);
    end else if (do_pop && !do_push) begin
      count_next = count - COUNT_WIDTH'(1);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      o_empty <= 1'b1;
      o_full  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + PTR_WIDTH'(1);
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + PTR_WIDTH'(1);
      end
      count   <= count_next;
      o_empty <= (count_next == '0);
      o_full  <= (count_next == COUNT_WIDTH'(DEPTH));
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it.
# Exits non-zero if the build fails or the run reports a failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --top-module bridge_tb \
  -Mdir "$BUILD_DIR" -f axi_corebus_bridge.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/Vbridge_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TEST RESULT: FAIL" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

echo "simulation passed"
exit 0
